// ==== mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	//////////////////////////////
	// Architectural types
	//////////////////////////////

	typedef logic [31:0] word_t;     // Data or address word
	typedef logic [4:0]  regIdx_t;   // GPR number
	typedef logic [5:0]  opcode_t;   // instr[31:26]
	typedef logic [5:0]  funct_t;    // instr[5:0], R-type only
	typedef logic [25:0] jumpIdx_t;  // J-type word index

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	localparam opcode_t opR    = 6'b000000;  // Special, look at funct
	localparam opcode_t opJ    = 6'b000010;
	localparam opcode_t opJal  = 6'b000011;
	localparam opcode_t opBeq  = 6'b000100;
	localparam opcode_t opAddi = 6'b001000;
	localparam opcode_t opOri  = 6'b001101;
	localparam opcode_t opLui  = 6'b001111;
	localparam opcode_t opLw   = 6'b100011;
	localparam opcode_t opSw   = 6'b101011;

	// Function codes under opR
	localparam funct_t fnAdd = 6'b100000;
	localparam funct_t fnSub = 6'b100010;
	localparam funct_t fnJr  = 6'b001000;

	//////////////////////////////
	// Register file and memory
	//////////////////////////////

	localparam regIdx_t linkReg = 5'd31;  // jal destination

	localparam int dmemWords    = 64;                  // Data memory depth in words
	localparam int dmemAddrBits = $clog2(dmemWords);   // Word index width

endpackage

`default_nettype wire

// ==== mipsCtrlPkg.sv ====
`default_nettype none

package mipsCtrlPkg;

	//////////////////////////////
	// Selector encodings
	//////////////////////////////

	// Destination register select
	typedef enum logic [1:0] {
		dstRt   = 2'd0,  // I-type
		dstRd   = 2'd1,  // R-type
		dstLink = 2'd2   // jal writes r31
	} regDst_t;

	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluOr  = 2'd2,
		aluLui = 2'd3    // Operand B moved to upper half
	} aluOp_t;

	// Writeback source
	typedef enum logic [1:0] {
		wbAlu = 2'd0,
		wbMem = 2'd1,    // lw
		wbPc4 = 2'd2     // Return address
	} wbSel_t;

	typedef enum logic [1:0] {
		npcSeq  = 2'd0,  // pc + 4
		npcJump = 2'd1,  // j, jal
		npcBeq  = 2'd2,  // Taken only on equal
		npcReg  = 2'd3   // jr
	} npcOp_t;

	//////////////////////////////
	// Decoded control bundle
	//////////////////////////////

	typedef struct packed {
		logic    regWrite;
		logic    signExt;   // Else zero extension
		logic    aluImm;    // ALU operand B from imm
		logic    memWrite;
		regDst_t regDst;
		aluOp_t  aluOp;
		wbSel_t  wbSel;
		npcOp_t  npcOp;
	} ctrl_t;

	// No architectural effect at all
	localparam ctrl_t ctrlNop = '{
		regWrite: 1'b0, signExt: 1'b0, aluImm: 1'b0, memWrite: 1'b0,
		regDst: dstRt, aluOp: aluAdd, wbSel: wbAlu, npcOp: npcSeq
	};

endpackage

`default_nettype wire

// ==== stageIf.sv ====
`default_nettype none

// One decoded instruction moving between two stages
interface stageIf import mipsIsaPkg::*, mipsCtrlPkg::*; ();

	logic     valid;   // Beat present this cycle
	ctrl_t    ctrl;
	word_t    pc;
	regIdx_t  rs;
	regIdx_t  rt;
	regIdx_t  rd;
	word_t    imm;     // Already extended
	jumpIdx_t target;  // J-type index

	modport producer (
		output valid, ctrl, pc, rs, rt, rd, imm, target
	);

	modport consumer (
		input valid, ctrl, pc, rs, rt, rd, imm, target
	);

endinterface

`default_nettype wire

// ==== ctrlDecoder.sv ====
`default_nettype none

module ctrlDecoder import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   instrValid,
	input  word_t  instr,
	input  word_t  instrPc,
	input  logic   flush,
	stageIf.producer decodeIf
);

	//////////////////////////////
	// Input register
	//////////////////////////////

	logic    validQ;
	word_t   instrQ;
	word_t   pcQ;

	always_ff @(posedge clk) begin
		if (reset) begin
			validQ <= 1'b0;
		end else begin
			validQ <= instrValid & ~flush;  // Input at the flush edge is younger, drop it
		end
	end

	always_ff @(posedge clk) begin
		instrQ <= instr;
		pcQ    <= instrPc;
	end

	//////////////////////////////
	// Instruction match
	//////////////////////////////

	opcode_t op;
	funct_t  fn;
	logic    isR;
	logic    isAdd, isSub, isJr;
	logic    isAddi, isOri, isLui, isLw, isSw, isBeq, isJ, isJal;
	ctrl_t   dec;

	assign op = instrQ[31:26];
	assign fn = instrQ[5:0];

	assign isR    = (op == opR);
	assign isAdd  = isR && (fn == fnAdd);
	assign isSub  = isR && (fn == fnSub);
	assign isJr   = isR && (fn == fnJr);
	assign isAddi = (op == opAddi);
	assign isOri  = (op == opOri);
	assign isLui  = (op == opLui);
	assign isLw   = (op == opLw);
	assign isSw   = (op == opSw);
	assign isBeq  = (op == opBeq);
	assign isJ    = (op == opJ);
	assign isJal  = (op == opJal);

	//////////////////////////////
	// Control equations
	//////////////////////////////

	always_comb begin
		dec = ctrlNop;  // Unknown encodings stay here
		dec.regWrite = isAdd | isSub | isOri | isLw | isLui | isJal | isAddi;
		dec.signExt  = isLw | isSw | isAddi | isBeq;
		dec.aluImm   = isOri | isLw | isSw | isLui | isAddi;
		dec.memWrite = isSw;

		if (isJal)              dec.regDst = dstLink;
		else if (isAdd | isSub) dec.regDst = dstRd;

		if (isSub)      dec.aluOp = aluSub;
		else if (isOri) dec.aluOp = aluOr;
		else if (isLui) dec.aluOp = aluLui;  // addi, lw, sw keep aluAdd

		if (isJal)     dec.wbSel = wbPc4;
		else if (isLw) dec.wbSel = wbMem;

		if (isBeq)            dec.npcOp = npcBeq;
		else if (isJr)        dec.npcOp = npcReg;
		else if (isJ | isJal) dec.npcOp = npcJump;
	end

	// Beat to the stage buffer
	assign decodeIf.valid  = validQ;
	assign decodeIf.ctrl   = dec;
	assign decodeIf.pc     = pcQ;
	assign decodeIf.rs     = instrQ[25:21];
	assign decodeIf.rt     = instrQ[20:16];
	assign decodeIf.rd     = instrQ[15:11];
	assign decodeIf.imm    = dec.signExt ? {{16{instrQ[15]}}, instrQ[15:0]}
	                                     : {16'h0000, instrQ[15:0]};
	assign decodeIf.target = instrQ[25:0];

	// Store and register write never together
	assert property (@(posedge clk) disable iff (reset)
		decodeIf.valid |-> !(decodeIf.ctrl.memWrite && decodeIf.ctrl.regWrite))
	else $error("decoder produced a beat with both memWrite and regWrite");

endmodule

`default_nettype wire

// ==== stageBuffer.sv ====
`default_nettype none

module stageBuffer (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	stageIf.consumer decodeIf,
	stageIf.producer execIf
);

	//////////////////////////////
	// Valid bit
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			execIf.valid <= 1'b0;  // Younger beat killed by a taken transfer
		end else begin
			execIf.valid <= decodeIf.valid;
		end
	end

	//////////////////////////////
	// Payload
	//////////////////////////////

	// Beat fields follow the decoder one cycle later
	always_ff @(posedge clk) begin
		execIf.ctrl   <= decodeIf.ctrl;
		execIf.pc     <= decodeIf.pc;
		execIf.rs     <= decodeIf.rs;
		execIf.rt     <= decodeIf.rt;
		execIf.rd     <= decodeIf.rd;
		execIf.imm    <= decodeIf.imm;
		execIf.target <= decodeIf.target;
	end

	// Flushed slot is empty next cycle
	assert property (@(posedge clk) disable iff (reset)
		flush |=> !execIf.valid)
	else $error("stage buffer kept a valid beat after flush");

endmodule

`default_nettype wire

// ==== execUnit.sv ====
`default_nettype none

module execUnit import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input  logic    clk,
	input  logic    reset,
	stageIf.consumer execIf,
	output logic    flush,
	output logic    wbValid,
	output regIdx_t wbReg,
	output word_t   wbData,
	output logic    memWrite,
	output word_t   memAddr,
	output word_t   memData,
	output logic    redirect,
	output word_t   redirectPc
);

	//////////////////////////////
	// Storage
	//////////////////////////////

	word_t regFile [0:31];         // r0 never written
	word_t dmem [0:dmemWords-1];   // Word addressed

	//////////////////////////////
	// Operands and ALU
	//////////////////////////////

	word_t rsVal;
	word_t rtVal;
	word_t aluB;
	word_t aluRes;

	assign rsVal = (execIf.rs == '0) ? '0 : regFile[execIf.rs];  // r0 reads zero
	assign rtVal = (execIf.rt == '0) ? '0 : regFile[execIf.rt];
	assign aluB  = execIf.ctrl.aluImm ? execIf.imm : rtVal;

	always_comb begin
		unique case (execIf.ctrl.aluOp)
			aluAdd:  aluRes = rsVal + aluB;
			aluSub:  aluRes = rsVal - aluB;
			aluOr:   aluRes = rsVal | aluB;
			aluLui:  aluRes = aluB << 16;  // imm zero extended, lands in upper half
			default: aluRes = rsVal + aluB;
		endcase
	end

	// Data memory port, bits 7:2 of the address
	logic [dmemAddrBits-1:0] memIdx;
	word_t                   memRdata;
	logic                    storeEn;

	assign memIdx   = aluRes[dmemAddrBits+1:2];
	assign memRdata = dmem[memIdx];
	assign storeEn  = execIf.valid && execIf.ctrl.memWrite;

	//////////////////////////////
	// Writeback select
	//////////////////////////////

	word_t   pcPlus4;
	regIdx_t dest;
	word_t   wbValue;
	logic    wbEn;

	assign pcPlus4 = execIf.pc + 32'd4;

	always_comb begin
		case (execIf.ctrl.regDst)
			dstRd:   dest = execIf.rd;
			dstLink: dest = linkReg;
			default: dest = execIf.rt;
		endcase
		case (execIf.ctrl.wbSel)
			wbMem:   wbValue = memRdata;
			wbPc4:   wbValue = pcPlus4;
			default: wbValue = aluRes;
		endcase
	end

	// Writes to r0 vanish completely
	assign wbEn = execIf.valid && execIf.ctrl.regWrite && (dest != '0);

	//////////////////////////////
	// Next PC
	//////////////////////////////

	word_t branchTarget;
	word_t jumpTarget;
	word_t nextPc;
	logic  taken;

	assign branchTarget = pcPlus4 + {execIf.imm[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], execIf.target, 2'b00};  // Same 256 MB region

	always_comb begin
		taken  = 1'b0;
		nextPc = pcPlus4;
		unique case (execIf.ctrl.npcOp)
			npcJump: begin
				taken  = 1'b1;
				nextPc = jumpTarget;
			end
			npcBeq: begin
				taken  = (rsVal == rtVal);
				nextPc = branchTarget;
			end
			npcReg: begin
				taken  = 1'b1;
				nextPc = rsVal;  // jr
			end
			default: ;  // Sequential
		endcase
	end

	assign flush = execIf.valid && taken;  // Kills decoder and buffer contents

	//////////////////////////////
	// State update
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (wbEn) regFile[dest] <= wbValue;  // Visible to the very next beat
		if (storeEn) dmem[memIdx] <= rtVal;
	end

	// Result strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			wbValid  <= 1'b0;
			memWrite <= 1'b0;
			redirect <= 1'b0;
		end else begin
			wbValid  <= wbEn;
			memWrite <= storeEn;
			redirect <= flush;
		end
	end

	always_ff @(posedge clk) begin
		wbReg      <= dest;
		wbData     <= wbValue;
		memAddr    <= aluRes;
		memData    <= rtVal;
		redirectPc <= nextPc;
	end

	// Store strobe traces back to a valid sw one cycle earlier
	assert property (@(posedge clk) disable iff (reset)
		memWrite |-> $past(execIf.valid && execIf.ctrl.memWrite))
	else $error("memWrite pulse without a store in execute");

	assert property (@(posedge clk) disable iff (reset)
		wbValid |-> (wbReg != '0))
	else $error("writeback reported for register 0");

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`default_nettype none

module mipsCore import mipsIsaPkg::*; (
	input  logic    clk,
	input  logic    reset,
	// Fetch side
	input  logic    instrValid,
	input  word_t   instr,
	input  word_t   instrPc,
	// Architectural results
	output logic    wbValid,
	output regIdx_t wbReg,
	output word_t   wbData,
	output logic    memWrite,
	output word_t   memAddr,
	output word_t   memData,
	output logic    redirect,
	output word_t   redirectPc
);

	stageIf decodeIf ();  // Decoder to buffer
	stageIf execIf ();    // Buffer to execute

	logic flush;  // Taken transfer in execute

	ctrlDecoder decoder (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.instrPc    (instrPc),
		.flush      (flush),
		.decodeIf   (decodeIf.producer)
	);

	stageBuffer buffer (
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.decodeIf (decodeIf.consumer),
		.execIf   (execIf.producer)
	);

	execUnit exec (
		.clk        (clk),
		.reset      (reset),
		.execIf     (execIf.consumer),
		.flush      (flush),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.memWrite   (memWrite),
		.memAddr    (memAddr),
		.memData    (memData),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

endmodule

`default_nettype wire

// ==== tbMips.sv ====
`default_nettype none

module tbMips import mipsIsaPkg::*, mipsCtrlPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////
	// Limits and table types
	//////////////////////////////

	localparam word_t progEnd      = 32'h0000_005C;  // First PC past the program
	localparam int    numEvents    = 18;
	localparam int    eventTimeout = 200;  // Cycles allowed per expected event
	localparam int    drainCycles  = 20;   // Quiet time after the last event

	typedef enum logic [1:0] {evWb, evMem, evRedir} evKind_t;

	typedef struct packed {
		evKind_t kind;
		word_t   a;  // Register, address or target
		word_t   b;  // Data, unused for redirect
	} outEvent_t;

	//////////////////////////////
	// DUT and clock
	//////////////////////////////

	logic    clk;
	logic    reset;
	logic    instrValid = 1'b0;
	word_t   instr      = '0;
	word_t   instrPc    = '0;
	logic    wbValid;
	regIdx_t wbReg;
	word_t   wbData;
	logic    memWrite;
	word_t   memAddr;
	word_t   memData;
	logic    redirect;
	word_t   redirectPc;

	word_t       progMem [0:31];   // Indexed by PC / 4
	outEvent_t   expTab [0:numEvents-1];
	outEvent_t   seenLog [0:63];   // Pulses seen by the monitor
	int          seenCount = 0;
	int          readIdx = 0;
	logic        running = 1'b0;   // Fetch and monitor active
	logic        gapsOn = 1'b0;
	word_t       fetchPc = '0;
	logic [15:0] lfsr = 16'd2070;

	mipsCore dut_i (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.instrPc    (instrPc),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.memWrite   (memWrite),
		.memAddr    (memAddr),
		.memData    (memData),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	//////////////////////////////
	// Encoders and helpers
	//////////////////////////////

	function automatic word_t encR(input regIdx_t rs, input regIdx_t rt, input regIdx_t rd,
	                               input funct_t fn);
		return {opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encI(input opcode_t op, input regIdx_t rs, input regIdx_t rt,
	                               input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encJ(input opcode_t op, input word_t dest);
		return {op, dest[27:2]};  // Word index of the target
	endfunction

	function automatic outEvent_t wbEv(input regIdx_t r, input word_t d);
		return '{kind: evWb, a: {27'd0, r}, b: d};
	endfunction

	function automatic outEvent_t memEv(input word_t addr, input word_t d);
		return '{kind: evMem, a: addr, b: d};
	endfunction

	function automatic outEvent_t redirEv(input word_t pc);
		return '{kind: evRedir, a: pc, b: 32'd0};
	endfunction

	// Galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) n = n ^ 16'hB400;
		return n;
	endfunction

	function automatic string kindName(input evKind_t k);
		case (k)
			evWb:    return "writeback";
			evMem:   return "memory write";
			default: return "redirect";
		endcase
	endfunction

	//////////////////////////////
	// Program and expected events
	//////////////////////////////

	task automatic loadTables();
		for (int i = 0; i < 32; i++) progMem[i] = 32'h0;
		progMem[0]  = encI(opLui, 5'd0, 5'd1, 16'h1234);        // lui r1
		progMem[1]  = encI(opOri, 5'd1, 5'd1, 16'h5678);        // Depends on r1 just written
		progMem[2]  = encI(opAddi, 5'd0, 5'd2, 16'hFFFD);       // r2 = -3
		progMem[3]  = encR(5'd1, 5'd2, 5'd3, fnAdd);
		progMem[4]  = encR(5'd1, 5'd2, 5'd4, fnSub);
		progMem[5]  = encI(opAddi, 5'd0, 5'd5, 16'h0040);       // Base 0x40
		progMem[6]  = encI(opSw, 5'd5, 5'd4, 16'hFFF8);         // sw r4, -8(r5)
		progMem[7]  = encI(opLw, 5'd5, 5'd6, 16'hFFF8);
		progMem[8]  = encI(opBeq, 5'd1, 5'd2, 16'd5);           // Not taken
		progMem[9]  = encI(opOri, 5'd0, 5'd7, 16'h00FF);
		progMem[10] = encI(opBeq, 5'd4, 5'd6, 16'd2);           // Taken to 0x34
		progMem[11] = encI(opAddi, 5'd0, 5'd8, 16'd1);          // Skipped
		progMem[12] = encI(opSw, 5'd0, 5'd0, 16'd0);            // Skipped
		progMem[13] = encJ(opJal, 32'h0000_004C);
		progMem[14] = encI(opAddi, 5'd0, 5'd0, 16'd5);          // jr lands here, r0 write
		progMem[15] = 32'hFC0A_5A5A;                            // Unknown opcode
		progMem[16] = encR(5'd0, 5'd7, 5'd9, fnAdd);            // r0 must read zero
		progMem[17] = encJ(opJ, 32'h0000_0054);
		progMem[18] = encI(opAddi, 5'd0, 5'd10, 16'd9);         // Skipped
		progMem[19] = encI(opAddi, 5'd0, 5'd11, 16'h0011);      // jal target
		progMem[20] = encR(5'd31, 5'd0, 5'd0, fnJr);
		progMem[21] = encI(opSw, 5'd5, 5'd11, 16'h0004);        // Flushed once, then j target
		progMem[22] = encI(opLw, 5'd5, 5'd12, 16'h0004);

		// Hand computed results in retire order
		expTab[0]  = wbEv(5'd1, 32'h1234_0000);
		expTab[1]  = wbEv(5'd1, 32'h1234_5678);
		expTab[2]  = wbEv(5'd2, 32'hFFFF_FFFD);
		expTab[3]  = wbEv(5'd3, 32'h1234_5675);
		expTab[4]  = wbEv(5'd4, 32'h1234_567B);
		expTab[5]  = wbEv(5'd5, 32'h0000_0040);
		expTab[6]  = memEv(32'h0000_0038, 32'h1234_567B);
		expTab[7]  = wbEv(5'd6, 32'h1234_567B);
		expTab[8]  = wbEv(5'd7, 32'h0000_00FF);
		expTab[9]  = redirEv(32'h0000_0034);
		expTab[10] = wbEv(5'd31, 32'h0000_0038);  // jal link, same cycle as its redirect
		expTab[11] = redirEv(32'h0000_004C);
		expTab[12] = wbEv(5'd11, 32'h0000_0011);
		expTab[13] = redirEv(32'h0000_0038);
		expTab[14] = wbEv(5'd9, 32'h0000_00FF);
		expTab[15] = redirEv(32'h0000_0054);
		expTab[16] = memEv(32'h0000_0044, 32'h0000_0011);
		expTab[17] = wbEv(5'd12, 32'h0000_0011);
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic abortRun(input string why);
		$display("CHECKS FAILED");
		$display("%s", why);
		$fatal(1);
	endtask

	task automatic checkWb(input regIdx_t gotReg, input word_t gotData,
	                       input regIdx_t expReg, input word_t expData);
		if (gotReg !== expReg)
			abortRun($sformatf("error wbReg got %h expected %h", gotReg, expReg));
		if (gotData !== expData)
			abortRun($sformatf("error wbData got %h expected %h", gotData, expData));
	endtask

	task automatic checkMem(input word_t gotAddr, input word_t gotData,
	                        input word_t expAddr, input word_t expData);
		if (gotAddr !== expAddr)
			abortRun($sformatf("error memAddr got %h expected %h", gotAddr, expAddr));
		if (gotData !== expData)
			abortRun($sformatf("error memData got %h expected %h", gotData, expData));
	endtask

	task automatic checkRedirect(input word_t gotPc, input word_t expPc);
		if (gotPc !== expPc)
			abortRun($sformatf("error redirectPc got %h expected %h", gotPc, expPc));
	endtask

	task automatic nextEvent(output outEvent_t ev);
		int waited;
		waited = 0;
		while (seenCount == readIdx) begin
			if (waited >= eventTimeout)
				abortRun("timed out waiting for the next result pulse");
			@(posedge clk);
			waited++;
		end
		ev = seenLog[readIdx[5:0]];
		readIdx = readIdx + 1;
	endtask

	//////////////////////////////
	// Sequencing
	//////////////////////////////

	task automatic applyReset();
		running = 1'b0;
		@(negedge clk);
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		running = 1'b1;  // Fetch starts at PC 0 on the next falling edge
	endtask

	task automatic runProgram();
		outEvent_t got;
		outEvent_t exp;
		for (int i = 0; i < numEvents; i++) begin
			nextEvent(got);
			exp = expTab[i];
			if (got.kind != exp.kind)
				abortRun($sformatf("unexpected %s pulse where event %0d should be a %s",
				                   kindName(got.kind), i, kindName(exp.kind)));
			case (exp.kind)
				evWb:    checkWb(got.a[4:0], got.b, exp.a[4:0], exp.b);
				evMem:   checkMem(got.a, got.b, exp.a, exp.b);
				default: checkRedirect(got.a, exp.a);
			endcase
		end
		repeat (drainCycles) @(posedge clk);
		if (seenCount != readIdx)
			abortRun("unexpected result pulse after the last expected event");
	endtask

	// Fetch agent, inputs change on the falling edge
	always @(negedge clk) begin : fetchModel
		logic present;
		if (!running) begin
			fetchPc = '0;
			instrValid <= 1'b0;
			instr      <= '0;
			instrPc    <= '0;
		end else begin
			if (redirect) fetchPc = redirectPc;  // Restart after a taken transfer
			present = 1'b1;
			if (gapsOn) begin
				present = lfsr[0];  // One bit per decision
				lfsr = lfsrStep(lfsr);
			end
			if (present && (fetchPc < progEnd)) begin
				instrValid <= 1'b1;
				instr      <= progMem[fetchPc[6:2]];
				instrPc    <= fetchPc;
				fetchPc = fetchPc + 32'd4;
			end else begin
				instrValid <= 1'b0;  // Gap or end of program
			end
		end
	end

	// Outputs sampled mid cycle, fixed order within a cycle
	always @(negedge clk) begin : resultMonitor
		if (running) begin
			if (wbValid) begin
				seenLog[seenCount[5:0]] = wbEv(wbReg, wbData);
				seenCount = seenCount + 1;
			end
			if (memWrite) begin
				seenLog[seenCount[5:0]] = memEv(memAddr, memData);
				seenCount = seenCount + 1;
			end
			if (redirect) begin
				seenLog[seenCount[5:0]] = redirEv(redirectPc);
				seenCount = seenCount + 1;
			end
		end
	end

	initial begin
		reset = 1'b1;
		loadTables();
		for (int pass = 0; pass < 2; pass++) begin
			gapsOn = (pass == 1);  // Second pass with random gaps
			applyReset();
			runProgram();
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
mipsIsaPkg.sv
mipsCtrlPkg.sv
stageIf.sv
ctrlDecoder.sv
stageBuffer.sv
execUnit.sv
mipsCore.sv
tbMips.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it, exit status follows the simulation
verilator --binary --timing --assert --top-module tbMips -f files.f -o simMips &&
	./obj_dir/simMips ||
	exit 1
